//--- src.f
+incdir+.
sgmii_enc_pkg.sv
enc_5b6b.sv
enc_3b4b.sv
code_group_builder.sv
sgmii_8b10b_encoder.sv
tb_sgmii_8b10b_encoder.sv

//--- Bender.yml
package:
  name: sgmii_8b10b_encoder

sources:
  # RTL in compile order.
  - files:
      - sgmii_enc_pkg.sv
      - enc_5b6b.sv
      - enc_3b4b.sv
      - code_group_builder.sv
      - sgmii_8b10b_encoder.sv

  # Testbench with its reference model header.
  - target: test
    include_dirs:
      - .
    files:
      - tb_sgmii_8b10b_encoder.sv

//--- tb_enc_model.svh
// Reference 8b/10b encoder; control bytes must be one of the twelve valid ones.
`ifndef TB_ENC_MODEL_SVH
`define TB_ENC_MODEL_SVH

// Number of ones in a group or a sub-block.
function automatic int count_ones(input logic [9:0] v);
        int n;
        int i;
        n = 0;
        for (i = 0; i < 10; i++)
                n += v[i];
        return n;
endfunction

// abcdei as sent from a negative running disparity.
function automatic sub6_t six_table(input sub5_t x);
        sub6_t r;
        case (x)
        5'd0:  r = 6'b100111;
        5'd1:  r = 6'b011101;
        5'd2:  r = 6'b101101;
        5'd3:  r = 6'b110001;
        5'd4:  r = 6'b110101;
        5'd5:  r = 6'b101001;
        5'd6:  r = 6'b011001;
        5'd7:  r = 6'b111000;
        5'd8:  r = 6'b111001;
        5'd9:  r = 6'b100101;
        5'd10: r = 6'b010101;
        5'd11: r = 6'b110100;
        5'd12: r = 6'b001101;
        5'd13: r = 6'b101100;
        5'd14: r = 6'b011100;
        5'd15: r = 6'b010111;
        5'd16: r = 6'b011011;
        5'd17: r = 6'b100011;
        5'd18: r = 6'b010011;
        5'd19: r = 6'b110010;
        5'd20: r = 6'b001011;
        5'd21: r = 6'b101010;
        5'd22: r = 6'b011010;
        5'd23: r = 6'b111010;
        5'd24: r = 6'b110011;
        5'd25: r = 6'b100110;
        5'd26: r = 6'b010110;
        5'd27: r = 6'b110110;
        5'd28: r = 6'b001110;
        5'd29: r = 6'b101110;
        5'd30: r = 6'b011110;
        default: r = 6'b101011;
        endcase
        return r;
endfunction

// fghj for both disparities in the middle of the group.
function automatic sub4_t four_table(input sub3_t y, input logic k, input logic alt,
                                     input rd_t mid);
        sub4_t r;
        if (mid == RD_NEG) begin
                case (y)
                3'd0: r = 4'b1011;
                3'd1: r = k ? 4'b0110 : 4'b1001;
                3'd2: r = k ? 4'b1010 : 4'b0101;
                3'd3: r = 4'b1100;
                3'd4: r = 4'b1101;
                3'd5: r = k ? 4'b0101 : 4'b1010;
                3'd6: r = k ? 4'b1001 : 4'b0110;
                default: r = alt ? 4'b0111 : 4'b1110;
                endcase
        end else begin
                case (y)
                3'd0: r = 4'b0100;
                3'd1: r = 4'b1001;
                3'd2: r = 4'b0101;
                3'd3: r = 4'b0011;
                3'd4: r = 4'b0010;
                3'd5: r = 4'b1010;
                3'd6: r = 4'b0110;
                default: r = alt ? 4'b1000 : 4'b0001;
                endcase
        end
        return r;
endfunction

// Expected group for one character and the disparity it leaves behind.
function automatic code_group_t enc_ref(input data_byte_t d, input logic k, input rd_t rd_in,
                                        output rd_t rd_out);
        sub5_t x;
        sub3_t y;
        sub6_t six;
        sub4_t four;
        rd_t   mid;
        logic  alt;
        x = d[4:0];
        y = d[7:5];
        six = (k && x == 5'd28) ? 6'b001111 : six_table(x);
        if (rd_in == RD_POS && (count_ones(10'(six)) != 3 || x == 5'd7))
                six = ~six;
        mid = rd_in;
        if (count_ones(10'(six)) != 3)
                mid = (rd_in == RD_NEG) ? RD_POS : RD_NEG;
        alt = (y == 3'd7) && (k ||
              (mid == RD_NEG && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
              (mid == RD_POS && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
        four = four_table(y, k, alt, mid);
        rd_out = mid;
        if (count_ones(10'(four)) != 2)
                rd_out = (mid == RD_NEG) ? RD_POS : RD_NEG;
        return {six, four};
endfunction

// The twelve valid control characters, K28.0 to K28.7 first.
function automatic data_byte_t k_char(input int idx);
        data_byte_t r;
        case (idx)
        8:  r = 8'hF7;
        9:  r = 8'hFB;
        10: r = 8'hFD;
        11: r = 8'hFE;
        default: r = {3'(idx), 5'd28};
        endcase
        return r;
endfunction

// Compares a value with its expected value and stops the run on a mismatch.
task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
                $display("ERR %0t: %s, got %0b, expected %0b", $time, what, got, exp);
                $display("** FAIL **");
                $fatal(1, "stopped at first mismatch");
        end
endtask

`endif

//--- tb_sgmii_8b10b_encoder.sv
// Self-checking testbench with a fixed random seed; stops at the first mismatch.
`default_nettype none
`timescale 1ns/10ps

module tb_sgmii_8b10b_encoder;
        import sgmii_enc_pkg::*;

        `include "tb_enc_model.svh"

        localparam int N_RANDOM = 2000;

        // About 2350 symbols in all, plus reset and pipeline drain.
        localparam int MAX_CYCLES = 3000;

        logic        clk;
        logic        rst;
        data_byte_t  data;
        logic        is_k;
        code_group_t code_group;

        code_group_t exp_q[$];
        code_group_t exp_grp;
        code_group_t ref_grp;
        rd_t         ref_rd;
        rd_t         model_rd;
        rd_t         start_rd;
        rd_t         line_rd;
        int          cycles = 0;

        sgmii_8b10b_encoder sgmii_8b10b_encoder_inst (
                .clk        (clk),
                .rst        (rst),
                .data       (data),
                .is_k       (is_k),
                .code_group (code_group)
        );

        initial clk = 1'b0;

        always #10 clk = ~clk;

        // **************************************************************************
        // Stimulus helpers.
        // **************************************************************************

        task automatic apply_reset();
                rst = 1'b1;
                @(negedge clk);
                check_value(code_group, '0, "code group during reset");
                // Reset content of the first stage is D0.0.
                ref_grp = enc_ref(8'h00, 1'b0, model_rd, ref_rd);
                check_value(ref_grp, 10'b1001110100, "model group for D0.0 after reset");
                check_value(ref_rd, RD_NEG, "model disparity after D0.0");
                model_rd = ref_rd;
                exp_q.push_back(ref_grp);
                @(negedge clk);
                rst = 1'b0;
        endtask

        task automatic send_char(input data_byte_t d, input logic k);
                code_group_t grp;
                rd_t         rd_after;
                grp = enc_ref(d, k, model_rd, rd_after);
                model_rd = rd_after;
                exp_q.push_back(grp);
                data = d;
                is_k = k;
                @(negedge clk);
        endtask

        // Line disparity seen from the output alone.
        task automatic watch_line(input code_group_t grp);
                int n;
                n = count_ones(grp);
                check_value(n == 4 || n == 5 || n == 6, 1'b1, "group disparity out of range");
                if (n == 6) begin
                        check_value(line_rd == RD_NEG, 1'b1, "two positive groups in a row");
                        line_rd = RD_POS;
                end else if (n == 4) begin
                        check_value(line_rd == RD_POS, 1'b1, "two negative groups in a row");
                        line_rd = RD_NEG;
                end
        endtask

        // **************************************************************************
        // Comparing process.
        // **************************************************************************

        // Reads the group registered on the previous edge.
        initial begin : compare_proc
                @(negedge rst);
                @(posedge clk);
                forever begin
                        @(posedge clk);
                        if (exp_q.size() != 0) begin
                                exp_grp = exp_q.pop_front();
                                check_value(code_group, exp_grp, "code group");
                                watch_line(code_group);
                        end
                end
        end

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        $display("Timeout: the test did not finish within %0d cycles", cycles);
                        $display("** FAIL **");
                        $fatal(1, "run stopped by timeout");
                end
        end

        initial begin
                void'($urandom(49));
                rst = 1'b1;
                data = '0;
                is_k = 1'b0;
                model_rd = RD_NEG;
                line_rd = RD_NEG;
                apply_reset();

                for (int i = 0; i < 256; i++)
                        send_char(8'(i), 1'b0);

                // Each control character from both disparities; D3.0 flips the line.
                for (int i = 0; i < 12; i++) begin
                        start_rd = model_rd;
                        send_char(k_char(i), 1'b1);
                        if (model_rd == start_rd)
                                send_char(8'h03, 1'b0);
                        send_char(k_char(i), 1'b1);
                end

                ref_grp = enc_ref(8'hBC, 1'b1, RD_NEG, ref_rd);
                check_value(ref_grp, 10'b0011111010, "model K28.5 from negative");
                ref_grp = enc_ref(8'hBC, 1'b1, RD_POS, ref_rd);
                check_value(ref_grp, 10'b1100000101, "model K28.5 from positive");
                repeat (6)
                        send_char(8'hBC, 1'b1);

                // /I1/ ordered set.
                repeat (20) begin
                        send_char(8'hBC, 1'b1);
                        send_char(8'hC5, 1'b0);
                end

                for (int i = 0; i < N_RANDOM; i++) begin
                        if ($urandom_range(9) == 0)
                                send_char(k_char($urandom_range(11)), 1'b1);
                        else
                                send_char(8'($urandom_range(255)), 1'b0);
                end

                while (exp_q.size() != 0)
                        @(posedge clk);
                @(negedge clk);
                $display("** PASS **");
                $finish;
        end

endmodule

`default_nettype wire

//--- sgmii_8b10b_encoder.sv
// One lane with one character in and one group out per clock and a fixed two-cycle latency.
`default_nettype none
`timescale 1ns/10ps

module sgmii_8b10b_encoder (
        input  logic                       clk,
        input  logic                       rst,
        input  sgmii_enc_pkg::data_byte_t  data,
        input  logic                       is_k,
        output sgmii_enc_pkg::code_group_t code_group
);
        import sgmii_enc_pkg::*;

        sub6_t six_neg;
        sub6_t six_pos;
        logic  six_unbal;
        sub5_t low5;
        sub3_t hgf;
        logic  k_reg;

        // Stage one registers both 6-bit candidates.
        enc_5b6b u_enc_5b6b (
                .clk       (clk),
                .rst       (rst),
                .data      (data),
                .is_k      (is_k),
                .six_neg   (six_neg),
                .six_pos   (six_pos),
                .six_unbal (six_unbal),
                .low5      (low5),
                .hgf       (hgf),
                .k_reg     (k_reg)
        );

        // Stage two picks by disparity and registers the group.
        code_group_builder u_builder (
                .clk        (clk),
                .rst        (rst),
                .six_neg    (six_neg),
                .six_pos    (six_pos),
                .six_unbal  (six_unbal),
                .low5       (low5),
                .hgf        (hgf),
                .k_reg      (k_reg),
                .code_group (code_group)
        );

endmodule

`default_nettype wire

//--- code_group_builder.sv
// Running disparity starts negative after reset; code_group reads zero while in reset.
`default_nettype none
`timescale 1ns/10ps

module code_group_builder (
        input  logic                       clk,
        input  logic                       rst,
        input  sgmii_enc_pkg::sub6_t       six_neg,
        input  sgmii_enc_pkg::sub6_t       six_pos,
        input  logic                       six_unbal,
        input  sgmii_enc_pkg::sub5_t       low5,
        input  sgmii_enc_pkg::sub3_t       hgf,
        input  logic                       k_reg,
        output sgmii_enc_pkg::code_group_t code_group
);
        import sgmii_enc_pkg::*;

        rd_t         rd_q;
        rd_t         rd_mid;
        rd_t         rd_next;
        sub6_t       six_sel;
        sub4_t       four;
        logic        four_unbal;
        code_group_t group_next;
        logic [3:0]  grp_ones;

        function automatic rd_t rd_flip(input rd_t rd);
                return (rd == RD_NEG) ? RD_POS : RD_NEG;
        endfunction

        // **************************************************************************
        // Disparity through the group.
        // **************************************************************************

        assign six_sel = (rd_q == RD_NEG) ? six_neg : six_pos;

        assign rd_mid = six_unbal ? rd_flip(rd_q) : rd_q;

        enc_3b4b u_enc_3b4b (
                .hgf        (hgf),
                .low5       (low5),
                .k_reg      (k_reg),
                .rd_mid     (rd_mid),
                .four       (four),
                .four_unbal (four_unbal)
        );

        assign rd_next = four_unbal ? rd_flip(rd_mid) : rd_mid;

        assign group_next = {six_sel, four};

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        code_group <= '0;
                        rd_q       <= RD_NEG;
                end else begin
                        code_group <= group_next;
                        rd_q       <= rd_next;
                end
        end

        // **************************************************************************
        // Checks on the joined group.
        // **************************************************************************

        assign grp_ones = 4'($countones(group_next));

        // Both sub-blocks together never drift by more than two.
        a_weight: assert property (@(posedge clk) disable iff (rst)
                grp_ones inside {4'd4, 4'd5, 4'd6})
                else $error("code group %b has %0d ones", group_next, grp_ones);

        // A heavy group is only sent from negative and leaves the line positive.
        a_rd_up: assert property (@(posedge clk) disable iff (rst)
                (grp_ones == 4'd6) |-> (rd_q == RD_NEG) ##1 (rd_q == RD_POS))
                else $error("positive group sent from positive disparity");

        // A light group is only sent from positive and leaves the line negative.
        a_rd_down: assert property (@(posedge clk) disable iff (rst)
                (grp_ones == 4'd4) |-> (rd_q == RD_POS) ##1 (rd_q == RD_NEG))
                else $error("negative group sent from negative disparity");

endmodule

`default_nettype wire

//--- enc_3b4b.sv
// Purely combinational; rd_mid must already include the effect of the 6-bit sub-block.
`default_nettype none
`timescale 1ns/10ps

module enc_3b4b (
        input  sgmii_enc_pkg::sub3_t hgf,
        input  sgmii_enc_pkg::sub5_t low5,
        input  logic                 k_reg,
        input  sgmii_enc_pkg::rd_t   rd_mid,
        output sgmii_enc_pkg::sub4_t four,
        output logic                 four_unbal
);
        import sgmii_enc_pkg::*;

        sub4_t tbl4;
        sub4_t base4;
        logic  use_alt;
        logic  k_inv;
        logic  flip_pos;

        // 3b/4b table, form used while rd_mid is negative.
        always_comb begin
                case (hgf)
                3'd0: tbl4 = 4'b1011;
                3'd1: tbl4 = 4'b1001;
                3'd2: tbl4 = 4'b0101;
                3'd3: tbl4 = 4'b1100;
                3'd4: tbl4 = 4'b1101;
                3'd5: tbl4 = 4'b1010;
                3'd6: tbl4 = 4'b0110;
                default: tbl4 = 4'b1110;
                endcase
        end

        // Alternate x.7 avoids a run of five equal bits across the sub-block border.
        assign use_alt = (hgf == 3'd7) &&
                         (k_reg ||
                          (rd_mid == RD_NEG && low5 inside {5'd17, 5'd18, 5'd20}) ||
                          (rd_mid == RD_POS && low5 inside {5'd11, 5'd13, 5'd14}));

        assign base4 = use_alt ? 4'b0111 : tbl4;

        assign four_unbal = ($countones(base4) != 2);

        // Control characters invert the balanced forms to keep the comma unique.
        assign k_inv = k_reg && (hgf inside {3'd1, 3'd2, 3'd5, 3'd6});

        // x.3 is balanced yet still alternates.
        assign flip_pos = four_unbal || (hgf == 3'd3);

        always_comb begin
                if (k_inv)
                        four = (rd_mid == RD_NEG) ? ~base4 : base4;
                else
                        four = (rd_mid == RD_POS && flip_pos) ? ~base4 : base4;
        end

endmodule

`default_nettype wire

//--- enc_5b6b.sv
// Accepts only the twelve valid control characters when is_k is high; resets to D0.0.
`default_nettype none
`timescale 1ns/10ps

module enc_5b6b (
        input  logic                      clk,
        input  logic                      rst,
        input  sgmii_enc_pkg::data_byte_t data,
        input  logic                      is_k,
        output sgmii_enc_pkg::sub6_t      six_neg,
        output sgmii_enc_pkg::sub6_t      six_pos,
        output logic                      six_unbal,
        output sgmii_enc_pkg::sub5_t      low5,
        output sgmii_enc_pkg::sub3_t      hgf,
        output logic                      k_reg
);
        import sgmii_enc_pkg::*;

        sub5_t edcba;
        sub6_t tbl6;
        sub6_t cand_neg;
        sub6_t cand_pos;
        logic  cand_unbal;
        logic  k_valid;

        assign edcba = data[4:0];

        // **************************************************************************
        // 5b/6b table, form used while the running disparity is negative.
        // **************************************************************************

        always_comb begin
                case (edcba)
                5'd0:  tbl6 = 6'b100111;
                5'd1:  tbl6 = 6'b011101;
                5'd2:  tbl6 = 6'b101101;
                5'd3:  tbl6 = 6'b110001;
                5'd4:  tbl6 = 6'b110101;
                5'd5:  tbl6 = 6'b101001;
                5'd6:  tbl6 = 6'b011001;
                5'd7:  tbl6 = 6'b111000;
                5'd8:  tbl6 = 6'b111001;
                5'd9:  tbl6 = 6'b100101;
                5'd10: tbl6 = 6'b010101;
                5'd11: tbl6 = 6'b110100;
                5'd12: tbl6 = 6'b001101;
                5'd13: tbl6 = 6'b101100;
                5'd14: tbl6 = 6'b011100;
                5'd15: tbl6 = 6'b010111;
                5'd16: tbl6 = 6'b011011;
                5'd17: tbl6 = 6'b100011;
                5'd18: tbl6 = 6'b010011;
                5'd19: tbl6 = 6'b110010;
                5'd20: tbl6 = 6'b001011;
                5'd21: tbl6 = 6'b101010;
                5'd22: tbl6 = 6'b011010;
                5'd23: tbl6 = 6'b111010;
                5'd24: tbl6 = 6'b110011;
                5'd25: tbl6 = 6'b100110;
                5'd26: tbl6 = 6'b010110;
                5'd27: tbl6 = 6'b110110;
                5'd28: tbl6 = 6'b001110;
                5'd29: tbl6 = 6'b101110;
                5'd30: tbl6 = 6'b011110;
                default: tbl6 = 6'b101011;
                endcase
        end

        // K28 has its own sub-block with a comma in it.
        assign cand_neg = (is_k && edcba == 5'd28) ? 6'b001111 : tbl6;

        assign cand_unbal = ($countones(cand_neg) != 3);

        // D.7 is balanced but still has two forms.
        assign cand_pos = (cand_unbal || edcba == 5'd7) ? ~cand_neg : cand_neg;

        assign k_valid = (edcba == 5'd28) || (data inside {8'hF7, 8'hFB, 8'hFD, 8'hFE});

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        // D0.0, balanced as a whole group.
                        six_neg   <= 6'b100111;
                        six_pos   <= 6'b011000;
                        six_unbal <= 1'b1;
                        low5      <= 5'd0;
                        hgf       <= 3'd0;
                        k_reg     <= 1'b0;
                end else begin
                        six_neg   <= cand_neg;
                        six_pos   <= cand_pos;
                        six_unbal <= cand_unbal;
                        low5      <= edcba;
                        hgf       <= data[7:5];
                        k_reg     <= is_k;
                end
        end

        // Control values outside the twelve have no code group.
        a_k_valid: assert property (@(posedge clk) disable iff (rst) is_k |-> k_valid)
                else $error("unsupported control character %h", data);

endmodule

`default_nettype wire

//--- sgmii_enc_pkg.sv
// Widths here are fixed by 8b/10b and cannot change; code group bit 9 is sent first.
`default_nettype none

package sgmii_enc_pkg;

        // **************************************************************************
        // Character side.
        // **************************************************************************

        // Input character HGFEDCBA with A in bit 0.
        typedef logic [7:0] data_byte_t;

        // The EDCBA part that feeds the 5b/6b sub-block.
        typedef logic [4:0] sub5_t;

        // The HGF part that feeds the 3b/4b sub-block.
        typedef logic [2:0] sub3_t;

        // **************************************************************************
        // Line side.
        // **************************************************************************

        // Sub-block abcdei with a in bit 5.
        typedef logic [5:0] sub6_t;

        // Sub-block fghj with f in bit 3.
        typedef logic [3:0] sub4_t;

        // Full group abcdeifghj with a in bit 9.
        typedef logic [9:0] code_group_t;

        // Running disparity between code groups.
        typedef enum logic {
                RD_NEG = 1'b0,
                RD_POS = 1'b1
        } rd_t;

endpackage

`default_nettype wire
